// File: hw/saturn_bus_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// saturn nibble bus controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module saturn_bus_ctrl #(
  parameter int ADDR_NIBBLES = 5
) (
  input  logic                                             i_clk,
  input  logic                                             cmd_RESET_start,
  input  logic                                             i_cmd_load_pc,
  input  logic                                             i_cmd_config,
  input  logic                                             i_cmd_dp_write,
  input  logic                                             i_alu_busy,
  input  logic [ADDR_NIBBLES*saturn_bus_pkg::NIBBLE_W-1:0] i_address,
  input  logic [saturn_bus_pkg::NIBBLE_W-1:0]              i_data_nibl,
  input  logic [saturn_bus_pkg::NIBBLE_W-1:0]              i_xfr_cnt,
  input  logic [saturn_bus_pkg::NIBBLE_W-1:0]              i_bus_data,
  output saturn_bus_pkg::bus_nibble_u                      o_bus_data,
  output logic                                             o_bus_cmd_data,
  output logic                                             o_bus_strobe,
  output logic                                             o_bus_reset,
  output logic                                             o_stall_alu,
  output logic                                             o_bus_done,
  output logic [saturn_bus_pkg::NIBBLE_W-1:0]              o_data_ptr,
  output logic [saturn_bus_pkg::NIBBLE_W-1:0]              o_nibble,
  output logic                                             o_nibble_valid
);

  logic [saturn_bus_pkg::NIBBLE_W-1:0] phase;
  saturn_bus_pkg::slot_kind_e          slot_kind;
  saturn_bus_pkg::bus_cmd_e            slot_cmd;
  logic                                ptr_clear;
  logic                                run_last;

  // single phase origin for both consumers
  saturn_phase_gen u_phase_gen (
    .i_clk           (i_clk),
    .cmd_RESET_start (cmd_RESET_start),
    .o_phase         (phase)
  );

  // slot sequencing, strobe and stall
  saturn_cmd_seq #(
    .ADDR_NIBBLES (ADDR_NIBBLES)
  ) u_cmd_seq (
    .i_clk           (i_clk),
    .cmd_RESET_start (cmd_RESET_start),
    .i_phase         (phase),
    .i_cmd_load_pc   (i_cmd_load_pc),
    .i_cmd_config    (i_cmd_config),
    .i_cmd_dp_write  (i_cmd_dp_write),
    .i_alu_busy      (i_alu_busy),
    .i_run_last      (run_last),
    .o_slot_kind     (slot_kind),
    .o_slot_cmd      (slot_cmd),
    .o_ptr_clear     (ptr_clear),
    .o_bus_cmd_data  (o_bus_cmd_data),
    .o_bus_strobe    (o_bus_strobe),
    .o_bus_reset     (o_bus_reset),
    .o_stall_alu     (o_stall_alu),
    .o_bus_done      (o_bus_done)
  );

  // nibble muxing, pointer and read capture
  saturn_nibble_path #(
    .ADDR_NIBBLES (ADDR_NIBBLES)
  ) u_nibble_path (
    .i_clk           (i_clk),
    .cmd_RESET_start (cmd_RESET_start),
    .i_phase         (phase),
    .i_slot_kind     (slot_kind),
    .i_slot_cmd      (slot_cmd),
    .i_ptr_clear     (ptr_clear),
    .i_address       (i_address),
    .i_data_nibl     (i_data_nibl),
    .i_xfr_cnt       (i_xfr_cnt),
    .i_bus_data      (i_bus_data),
    .o_bus_data      (o_bus_data),
    .o_data_ptr      (o_data_ptr),
    .o_run_last      (run_last),
    .o_nibble        (o_nibble),
    .o_nibble_valid  (o_nibble_valid)
  );

endmodule

// File: hw/saturn_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// saturn nibble bus shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package saturn_bus_pkg;

  // one bus nibble
  localparam int NIBBLE_W = 4;

  // clocks per bus slot
  localparam int PHASES = 4;

  // codes sent with cmd/data low
  // 1, 3, 4 and 7 reserved
  typedef enum logic [NIBBLE_W-1:0] {
    NOP       = 4'd0,
    PC_READ   = 4'd2,
    DP_WRITE  = 4'd5,
    LOAD_PC   = 4'd6,
    CONFIGURE = 4'd8
  } bus_cmd_e;

  // what the current slot carries
  typedef enum logic [2:0] {
    SLOT_IDLE  = 3'd0,
    SLOT_CMD   = 3'd1,
    SLOT_ADDR  = 3'd2,
    SLOT_WDATA = 3'd3,
    SLOT_READ  = 3'd4
  } slot_kind_e;

  // outgoing nibble
  // cmd view when cmd/data is low, raw data view otherwise
  typedef union packed {
    bus_cmd_e              cmd;
    logic [NIBBLE_W-1:0]   data;
  } bus_nibble_u;

endpackage

// File: hw/saturn_cmd_seq.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus command sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module saturn_cmd_seq #(
  parameter int ADDR_NIBBLES = 5
) (
  input  logic                                i_clk,
  input  logic                                cmd_RESET_start,
  input  logic [saturn_bus_pkg::NIBBLE_W-1:0] i_phase,
  input  logic                                i_cmd_load_pc,
  input  logic                                i_cmd_config,
  input  logic                                i_cmd_dp_write,
  input  logic                                i_alu_busy,
  input  logic                                i_run_last,
  output saturn_bus_pkg::slot_kind_e          o_slot_kind,
  output saturn_bus_pkg::bus_cmd_e            o_slot_cmd,
  output logic                                o_ptr_clear,
  output logic                                o_bus_cmd_data,
  output logic                                o_bus_strobe,
  output logic                                o_bus_reset,
  output logic                                o_stall_alu,
  output logic                                o_bus_done
);

  // FSM states, one per kind of slot sequence
  localparam logic [2:0] ST_START     = 3'd0;
  localparam logic [2:0] ST_START_CMD = 3'd1;
  localparam logic [2:0] ST_READ      = 3'd2;
  localparam logic [2:0] ST_CMD       = 3'd3;
  localparam logic [2:0] ST_ADDR      = 3'd4;
  localparam logic [2:0] ST_WRITE     = 3'd5;
  localparam logic [2:0] ST_CLOSE     = 3'd6;

  // address pointer is one nibble wide in the datapath
  if (ADDR_NIBBLES < 1 || ADDR_NIBBLES > (1 << saturn_bus_pkg::NIBBLE_W)) begin : g_bad_addr
    $error("ADDR_NIBBLES out of range for the nibble pointer");
  end

  logic [2:0]                 state;
  saturn_bus_pkg::bus_cmd_e   cur_cmd;
  saturn_bus_pkg::bus_cmd_e   sel_cmd;
  saturn_bus_pkg::slot_kind_e kind_p0;
  saturn_bus_pkg::slot_kind_e kind_q;
  logic                       strobe_q;
  logic                       run_start;
  logic                       any_req;
  logic                       accept;
  logic                       slot_end;
  logic                       release_stall;

  assign any_req  = i_cmd_load_pc | i_cmd_config | i_cmd_dp_write;
  assign slot_end = i_phase[3];

  // requests only looked at on phase 0 of a read-mode slot
  assign accept = i_phase[0] && (state == ST_READ) && !o_stall_alu && any_req;

  // load_pc wins over config, config over dp_write
  always_comb begin
    if (i_cmd_load_pc) begin
      sel_cmd = saturn_bus_pkg::LOAD_PC;
    end else if (i_cmd_config) begin
      sel_cmd = saturn_bus_pkg::CONFIGURE;
    end else begin
      sel_cmd = saturn_bus_pkg::DP_WRITE;
    end
  end

  // slot kind as decided on phase 0
  always_comb begin
    case (state)
      ST_START_CMD,
      ST_CMD,
      ST_CLOSE: kind_p0 = saturn_bus_pkg::SLOT_CMD;
      ST_ADDR:  kind_p0 = saturn_bus_pkg::SLOT_ADDR;
      ST_WRITE: kind_p0 = saturn_bus_pkg::SLOT_WDATA;
      ST_READ: begin
        // accepted command turns this slot into its command slot
        if (accept) begin
          kind_p0 = saturn_bus_pkg::SLOT_CMD;
        end else if (i_alu_busy) begin
          kind_p0 = saturn_bus_pkg::SLOT_IDLE;
        end else begin
          kind_p0 = saturn_bus_pkg::SLOT_READ;
        end
      end
      default:  kind_p0 = saturn_bus_pkg::SLOT_IDLE;
    endcase
  end

  // held for phases 1 to 3
  assign o_slot_kind = i_phase[0] ? kind_p0 : kind_q;

  // command nibble for the datapath, used on phase 0
  always_comb begin
    case (state)
      ST_READ:  o_slot_cmd = sel_cmd;
      ST_START_CMD,
      ST_CLOSE: o_slot_cmd = saturn_bus_pkg::PC_READ;
      default:  o_slot_cmd = cur_cmd;
    endcase
  end

  assign o_bus_cmd_data = (o_slot_kind != saturn_bus_pkg::SLOT_CMD);
  assign o_bus_strobe   = i_phase[1] & strobe_q;
  assign o_ptr_clear    = i_phase[0] & run_start;

  // end of startup read cmd, closing PC_READ, or last LOAD_PC address nibble
  assign release_stall = slot_end &&
                         ((state == ST_START_CMD) || (state == ST_CLOSE) ||
                          ((state == ST_ADDR) && i_run_last &&
                           (cur_cmd == saturn_bus_pkg::LOAD_PC)));

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_start) begin
      state       <= ST_START;
      cur_cmd     <= saturn_bus_pkg::NOP;
      kind_q      <= saturn_bus_pkg::SLOT_IDLE;
      strobe_q    <= 1'b0;
      run_start   <= 1'b0;
      o_bus_reset <= 1'b1;
      o_stall_alu <= 1'b1;
      o_bus_done  <= 1'b0;
    end else begin
      // done sits in phase 3 of the closing PC_READ
      o_bus_done <= i_phase[2] && (state == ST_CLOSE);

      if (i_phase[0]) begin
        kind_q    <= kind_p0;
        // startup slot strobes with nothing on the bus
        strobe_q  <= (kind_p0 != saturn_bus_pkg::SLOT_IDLE) || (state == ST_START);
        run_start <= 1'b0;
      end

      // single startup strobe releases bus reset
      if ((state == ST_START) && i_phase[1]) begin
        o_bus_reset <= 1'b0;
        o_stall_alu <= 1'b0;
      end

      if (accept) begin
        state       <= ST_CMD;
        cur_cmd     <= sel_cmd;
        o_stall_alu <= 1'b1;
      end

      if (release_stall) begin
        o_stall_alu <= 1'b0;
      end

      // slot boundary moves
      if (slot_end) begin
        case (state)
          ST_START: begin
            state       <= ST_START_CMD;
            o_stall_alu <= 1'b1;
          end
          ST_START_CMD,
          ST_CLOSE: begin
            state   <= ST_READ;
            cur_cmd <= saturn_bus_pkg::PC_READ;
          end
          ST_CMD: begin
            state     <= (cur_cmd == saturn_bus_pkg::DP_WRITE) ? ST_WRITE : ST_ADDR;
            run_start <= 1'b1;
          end
          ST_ADDR: begin
            if (i_run_last) begin
              // LOAD_PC drops straight into reads, CONFIGURE closes
              if (cur_cmd == saturn_bus_pkg::LOAD_PC) begin
                state   <= ST_READ;
                cur_cmd <= saturn_bus_pkg::PC_READ;
              end else begin
                state <= ST_CLOSE;
              end
            end
          end
          ST_WRITE: begin
            if (i_run_last) begin
              state <= ST_CLOSE;
            end
          end
          default: begin
            state <= state;
          end
        endcase
      end
    end
  end

endmodule

// File: hw/saturn_nibble_path.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus nibble datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module saturn_nibble_path #(
  parameter int ADDR_NIBBLES = 5
) (
  input  logic                                             i_clk,
  input  logic                                             cmd_RESET_start,
  input  logic [saturn_bus_pkg::NIBBLE_W-1:0]              i_phase,
  input  saturn_bus_pkg::slot_kind_e                       i_slot_kind,
  input  saturn_bus_pkg::bus_cmd_e                         i_slot_cmd,
  input  logic                                             i_ptr_clear,
  input  logic [ADDR_NIBBLES*saturn_bus_pkg::NIBBLE_W-1:0] i_address,
  input  logic [saturn_bus_pkg::NIBBLE_W-1:0]              i_data_nibl,
  input  logic [saturn_bus_pkg::NIBBLE_W-1:0]              i_xfr_cnt,
  input  logic [saturn_bus_pkg::NIBBLE_W-1:0]              i_bus_data,
  output saturn_bus_pkg::bus_nibble_u                      o_bus_data,
  output logic [saturn_bus_pkg::NIBBLE_W-1:0]              o_data_ptr,
  output logic                                             o_run_last,
  output logic [saturn_bus_pkg::NIBBLE_W-1:0]              o_nibble,
  output logic                                             o_nibble_valid
);

  localparam int NW = saturn_bus_pkg::NIBBLE_W;
  localparam logic [NW-1:0] LAST_ADDR = NW'(ADDR_NIBBLES - 1);

  logic          in_run;
  logic          capture;
  logic [NW-1:0] addr_nibl;

  assign in_run = (i_slot_kind == saturn_bus_pkg::SLOT_ADDR) ||
                  (i_slot_kind == saturn_bus_pkg::SLOT_WDATA);

  // address goes out low nibble first
  assign addr_nibl = i_address[o_data_ptr*NW +: NW];

  // run length: fixed for addresses, xfr_cnt + 1 for write data
  always_comb begin
    case (i_slot_kind)
      saturn_bus_pkg::SLOT_ADDR:  o_run_last = (o_data_ptr == LAST_ADDR);
      saturn_bus_pkg::SLOT_WDATA: o_run_last = (o_data_ptr == i_xfr_cnt);
      default:                    o_run_last = 1'b0;
    endcase
  end

  // pointer steps at slot end and wraps to 0 after the last nibble
  // so it already reads 0 on phase 0 of the next run
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_start || i_ptr_clear) begin
      o_data_ptr <= '0;
    end else if (i_phase[3] && in_run) begin
      o_data_ptr <= o_run_last ? '0 : o_data_ptr + 1'b1;
    end
  end

  // outgoing nibble, valid from phase 1 on
  always_ff @(posedge i_clk) begin
    if (i_phase[0]) begin
      case (i_slot_kind)
        saturn_bus_pkg::SLOT_CMD:   o_bus_data.cmd  <= i_slot_cmd;
        saturn_bus_pkg::SLOT_ADDR:  o_bus_data.data <= addr_nibl;
        saturn_bus_pkg::SLOT_WDATA: o_bus_data.data <= i_data_nibl;
        default:                    o_bus_data      <= o_bus_data;
      endcase
    end
  end

  // read nibble sampled while the strobe is up
  assign capture = i_phase[1] && (i_slot_kind == saturn_bus_pkg::SLOT_READ);

  always_ff @(posedge i_clk) begin
    if (capture) begin
      o_nibble <= i_bus_data;
    end
  end

  // valid lands in phase 2 alongside the new nibble
  always_ff @(posedge i_clk) begin
    if (cmd_RESET_start) begin
      o_nibble_valid <= 1'b0;
    end else begin
      o_nibble_valid <= capture;
    end
  end

endmodule

// File: hw/saturn_phase_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-phase slot timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module saturn_phase_gen (
  input  logic                                i_clk,
  input  logic                                cmd_RESET_start,
  output logic [saturn_bus_pkg::NIBBLE_W-1:0] o_phase
);

  localparam int CNT_W = $clog2(saturn_bus_pkg::PHASES);

  // position inside the current slot
  logic [CNT_W-1:0] slot_cnt;

  always_ff @(posedge i_clk) begin
    if (cmd_RESET_start) begin
      // first clock after reset is phase 0
      slot_cnt <= '0;
    end else if (slot_cnt == CNT_W'(saturn_bus_pkg::PHASES - 1)) begin
      slot_cnt <= '0;
    end else begin
      slot_cnt <= slot_cnt + 1'b1;
    end
  end

  // one-hot decode for sequencer and datapath
  always_comb begin
    o_phase           = '0;
    o_phase[slot_cnt] = 1'b1;
  end

endmodule

// File: list.f
hw/saturn_bus_pkg.sv
hw/saturn_phase_gen.sv
hw/saturn_cmd_seq.sv
hw/saturn_nibble_path.sv
hw/saturn_bus_ctrl.sv
verif/saturn_clk_gen.sv
verif/saturn_bus_ctrl_props.sv
verif/saturn_bus_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# build and run the bus controller testbench with Verilator
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert --top-module saturn_bus_ctrl_tb -f list.f \
  -o saturn_sim > "$LOG" 2>&1 && ./obj_dir/saturn_sim >> "$LOG" 2>&1 \
  || echo "CHECKS FAILED (build or simulation error)" >> "$LOG"
cat "$LOG"
grep -q "CHECKS FAILED" "$LOG" && exit 1 || exit 0

// File: verif/saturn_bus_ctrl_props.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus controller properties
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module saturn_bus_ctrl_props (
  input logic i_clk,
  input logic cmd_RESET_start,
  input logic o_bus_strobe,
  input logic o_bus_done,
  input logic o_bus_reset
);

  // strobe only ever sits in phase 1
  a_strobe_single : assert property (@(posedge i_clk) disable iff (cmd_RESET_start)
    o_bus_strobe |=> !o_bus_strobe)
    else $error("bus strobe high on two consecutive cycles");

  // done is a one-cycle pulse
  a_done_single : assert property (@(posedge i_clk) disable iff (cmd_RESET_start)
    o_bus_done |=> !o_bus_done)
    else $error("bus done held longer than one cycle");

  // bus reset is released once and stays released
  a_reset_stays : assert property (@(posedge i_clk) disable iff (cmd_RESET_start)
    !o_bus_reset |=> !o_bus_reset)
    else $error("bus reset rose again after release");

endmodule

bind saturn_bus_ctrl saturn_bus_ctrl_props u_props (
  .i_clk           (i_clk),
  .cmd_RESET_start (cmd_RESET_start),
  .o_bus_strobe    (o_bus_strobe),
  .o_bus_done      (o_bus_done),
  .o_bus_reset     (o_bus_reset)
);

// File: verif/saturn_bus_ctrl_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// saturn bus controller testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module saturn_bus_ctrl_tb;

  localparam int AN   = 5;
  localparam int NW   = saturn_bus_pkg::NIBBLE_W;
  localparam int AW   = AN * NW;
  localparam int ROWS = 7;

  logic          clk;
  logic          rst;
  logic          i_cmd_load_pc;
  logic          i_cmd_config;
  logic          i_cmd_dp_write;
  logic          i_alu_busy;
  logic [AW-1:0] i_address;
  logic [NW-1:0] i_data_nibl;
  logic [NW-1:0] i_xfr_cnt;
  logic [NW-1:0] i_bus_data;

  saturn_bus_pkg::bus_nibble_u o_bus_data;
  logic          o_bus_cmd_data;
  logic          o_bus_strobe;
  logic          o_bus_reset;
  logic          o_stall_alu;
  logic          o_bus_done;
  logic [NW-1:0] o_data_ptr;
  logic [NW-1:0] o_nibble;
  logic          o_nibble_valid;

  // stimulus table, one command per row, NOP row is reads only
  saturn_bus_pkg::bus_cmd_e row_cmd[ROWS];
  logic [2:0]    row_req[ROWS];
  logic [NW-1:0] row_xfr[ROWS];
  int            row_reads[ROWS];
  logic [15:0]   row_busy[ROWS];
  logic [AW-1:0] row_addr[ROWS];
  logic [NW-1:0] row_wdata[ROWS][16];
  logic [NW-1:0] wdata_cur[16];

  int tb_phase;
  int model_cnt;
  int rd_idx;

  saturn_clk_gen u_clk_gen (
    .o_clk (clk),
    .o_rst (rst)
  );

  saturn_bus_ctrl #(
    .ADDR_NIBBLES (AN)
  ) dut (
    .i_clk           (clk),
    .cmd_RESET_start (rst),
    .i_cmd_load_pc   (i_cmd_load_pc),
    .i_cmd_config    (i_cmd_config),
    .i_cmd_dp_write  (i_cmd_dp_write),
    .i_alu_busy      (i_alu_busy),
    .i_address       (i_address),
    .i_data_nibl     (i_data_nibl),
    .i_xfr_cnt       (i_xfr_cnt),
    .i_bus_data      (i_bus_data),
    .o_bus_data      (o_bus_data),
    .o_bus_cmd_data  (o_bus_cmd_data),
    .o_bus_strobe    (o_bus_strobe),
    .o_bus_reset     (o_bus_reset),
    .o_stall_alu     (o_stall_alu),
    .o_bus_done      (o_bus_done),
    .o_data_ptr      (o_data_ptr),
    .o_nibble        (o_nibble),
    .o_nibble_valid  (o_nibble_valid)
  );

  // phase 0 is the first clock after reset, four clocks per slot
  always @(posedge clk) begin
    if (rst) begin
      tb_phase <= 0;
    end else begin
      tb_phase <= (tb_phase == saturn_bus_pkg::PHASES - 1) ? 0 : tb_phase + 1;
    end
  end

  // bus side read data, a fixed function of the read count
  function automatic logic [NW-1:0] bus_nibble_at(input int n);
    return NW'((n * 7 + 3) ^ (n >> 3));
  endfunction

  // bus model answers read strobes only
  always @(negedge clk) begin
    if (o_bus_strobe && !o_stall_alu) begin
      i_bus_data = bus_nibble_at(model_cnt);
      model_cnt++;
    end
  end

  // requester follows the data pointer
  always @(negedge clk) begin
    i_data_nibl = wdata_cur[o_data_ptr];
  end

  task automatic fail_now(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      fail_now($sformatf("ERROR at %0t: %s got %b expected %b", $time, name, act, exp));
    end
  endtask

  task automatic check_nibble(input string name, input saturn_bus_pkg::bus_nibble_u act,
                              input saturn_bus_pkg::bus_nibble_u exp);
    if (act.data !== exp.data) begin
      fail_now($sformatf("ERROR at %0t: %s got %h expected %h", $time, name,
                         act.data, exp.data));
    end
  endtask

  task automatic check_cmd(input string name, input saturn_bus_pkg::bus_cmd_e act,
                           input saturn_bus_pkg::bus_cmd_e exp);
    if (act !== exp) begin
      fail_now($sformatf("ERROR at %0t: %s got %h expected %h (%s)", $time, name,
                         act, exp, exp.name()));
    end
  endtask

  // next falling edge inside the given phase
  task automatic wait_phase(input int p);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 2 * saturn_bus_pkg::PHASES) begin
        fail_now($sformatf("timeout waiting for bus phase %0d", p));
      end
    end while (tb_phase != p);
  endtask

  // a command nibble strobed with cmd/data low
  task automatic expect_cmd_slot(input saturn_bus_pkg::bus_cmd_e cmd);
    wait_phase(1);
    check_bit("o_bus_strobe", o_bus_strobe, 1'b1);
    check_bit("o_bus_cmd_data", o_bus_cmd_data, 1'b0);
    check_cmd("o_bus_data.cmd", o_bus_data.cmd, cmd);
    check_bit("o_stall_alu", o_stall_alu, 1'b1);
    check_bit("o_bus_done", o_bus_done, 1'b0);
  endtask

  // a data or address nibble strobed with cmd/data high
  task automatic expect_data_slot(input logic [NW-1:0] nibl);
    wait_phase(1);
    check_bit("o_bus_strobe", o_bus_strobe, 1'b1);
    check_bit("o_bus_cmd_data", o_bus_cmd_data, 1'b1);
    check_nibble("o_bus_data", o_bus_data, nibl);
    check_bit("o_stall_alu", o_stall_alu, 1'b1);
  endtask

  task automatic do_reads(input int n, input logic [15:0] busy);
    int i;
    for (i = 0; i < n; i++) begin
      // busy is sampled on phase 0 of the slot
      i_alu_busy = busy[i];
      wait_phase(1);
      if (busy[i]) begin
        check_bit("o_bus_strobe", o_bus_strobe, 1'b0);
      end else begin
        check_bit("o_bus_strobe", o_bus_strobe, 1'b1);
        check_bit("o_bus_cmd_data", o_bus_cmd_data, 1'b1);
        check_bit("o_stall_alu", o_stall_alu, 1'b0);
      end
      wait_phase(2);
      if (busy[i]) begin
        check_bit("o_nibble_valid", o_nibble_valid, 1'b0);
      end else begin
        check_bit("o_nibble_valid", o_nibble_valid, 1'b1);
        check_nibble("o_nibble", o_nibble, bus_nibble_at(rd_idx));
        rd_idx++;
      end
      wait_phase(3);
    end
    i_alu_busy = 1'b0;
  endtask

  task automatic run_command(input int r);
    int k;
    saturn_bus_pkg::bus_cmd_e cmd;
    cmd = row_cmd[r];
    expect_cmd_slot(cmd);
    // accepted, so this level can drop
    case (cmd)
      saturn_bus_pkg::LOAD_PC:   i_cmd_load_pc = 1'b0;
      saturn_bus_pkg::CONFIGURE: i_cmd_config = 1'b0;
      default:                   i_cmd_dp_write = 1'b0;
    endcase
    wait_phase(3);
    if (cmd == saturn_bus_pkg::DP_WRITE) begin
      for (k = 0; k <= int'(row_xfr[r]); k++) begin
        expect_data_slot(row_wdata[r][k]);
        check_nibble("o_data_ptr", o_data_ptr, NW'(k));
        wait_phase(3);
        check_bit("o_bus_done", o_bus_done, 1'b0);
      end
    end else begin
      // address low nibble first
      for (k = 0; k < AN; k++) begin
        expect_data_slot(row_addr[r][k*NW +: NW]);
        wait_phase(3);
        check_bit("o_stall_alu", o_stall_alu, 1'b1);
        check_bit("o_bus_done", o_bus_done, 1'b0);
      end
    end
    if (cmd != saturn_bus_pkg::LOAD_PC) begin
      // closing PC_READ with done in phase 3
      expect_cmd_slot(saturn_bus_pkg::PC_READ);
      wait_phase(3);
      check_bit("o_bus_done", o_bus_done, 1'b1);
      check_bit("o_stall_alu", o_stall_alu, 1'b1);
    end
    wait_phase(0);
    check_bit("o_stall_alu", o_stall_alu, 1'b0);
    check_bit("o_bus_done", o_bus_done, 1'b0);
  endtask

  task automatic build_table();
    int r;
    int k;
    row_cmd = '{saturn_bus_pkg::LOAD_PC, saturn_bus_pkg::CONFIGURE, saturn_bus_pkg::DP_WRITE,
                saturn_bus_pkg::LOAD_PC, saturn_bus_pkg::CONFIGURE, saturn_bus_pkg::DP_WRITE,
                saturn_bus_pkg::NOP};
    // row 3 raises load_pc and config together, row 4 finds config still high
    row_req   = '{3'b001, 3'b010, 3'b100, 3'b011, 3'b000, 3'b100, 3'b000};
    row_xfr   = '{4'd0, 4'd0, 4'd3, 4'd0, 4'd0, 4'd0, 4'd0};
    row_reads = '{3, 4, 2, 2, 0, 3, 6};
    for (r = 0; r < ROWS; r++) begin
      row_addr[r] = AW'($urandom);
      row_busy[r] = 16'($urandom);
      for (k = 0; k < 16; k++) begin
        row_wdata[r][k] = NW'($urandom);
      end
    end
  endtask

  initial begin
    int r;
    void'($urandom(36268));
    i_cmd_load_pc  = 1'b0;
    i_cmd_config   = 1'b0;
    i_cmd_dp_write = 1'b0;
    i_alu_busy     = 1'b0;
    i_address      = '0;
    i_data_nibl    = '0;
    i_xfr_cnt      = '0;
    i_bus_data     = '0;
    model_cnt      = 0;
    rd_idx         = 0;
    wdata_cur      = '{default: '0};
    build_table();

    // state while reset is applied
    @(negedge clk);
    check_bit("o_bus_reset", o_bus_reset, 1'b1);
    check_bit("o_stall_alu", o_stall_alu, 1'b1);
    check_bit("o_bus_strobe", o_bus_strobe, 1'b0);
    check_bit("o_bus_done", o_bus_done, 1'b0);
    check_bit("o_nibble_valid", o_nibble_valid, 1'b0);
    check_bit("o_bus_cmd_data", o_bus_cmd_data, 1'b1);

    // startup: one bare strobe, then bus reset and stall drop
    wait_phase(1);
    check_bit("o_bus_strobe", o_bus_strobe, 1'b1);
    check_bit("o_bus_reset", o_bus_reset, 1'b1);
    wait_phase(2);
    check_bit("o_bus_reset", o_bus_reset, 1'b0);
    check_bit("o_stall_alu", o_stall_alu, 1'b0);
    wait_phase(3);
    check_bit("o_bus_strobe", o_bus_strobe, 1'b0);
    expect_cmd_slot(saturn_bus_pkg::PC_READ);
    wait_phase(3);
    check_bit("o_stall_alu", o_stall_alu, 1'b1);
    wait_phase(0);
    check_bit("o_stall_alu", o_stall_alu, 1'b0);

    for (r = 0; r < ROWS; r++) begin
      i_address = row_addr[r];
      i_xfr_cnt = row_xfr[r];
      wdata_cur = row_wdata[r];
      do_reads(row_reads[r], row_busy[r]);
      if (row_cmd[r] != saturn_bus_pkg::NOP) begin
        if (row_req[r][0]) i_cmd_load_pc = 1'b1;
        if (row_req[r][1]) i_cmd_config = 1'b1;
        if (row_req[r][2]) i_cmd_dp_write = 1'b1;
        run_command(r);
      end
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: verif/saturn_clk_gen.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench clock and reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module saturn_clk_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // reset drops on a falling edge, like every other input
  initial begin
    o_rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst = 1'b0;
  end

endmodule
